/* build.f */
core_pkg.sv
mem_stage.sv
data_ram.sv
wb_stage.sv
mem_wb_top.sv
mem_stage_chk.sv
tb_mem_wb_top.sv

/* run.sh */
#!/bin/sh
# Builds and runs the memory/writeback testbench with Verilator.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_mem_wb_top -o sim_tb -f build.f

# tee keeps the pipeline status, so the log search below decides the result.
./obj_dir/sim_tb +verilator+error+limit+10 2>&1 | tee sim.log

if grep -q "^Verification passed$" sim.log; then
    echo "run.sh: simulation passed"
else
    echo "run.sh: simulation did not pass"
    exit 1
fi

/* mem_stimulus.txt */
# valid reg_pc inst rs2_data alu_out br_flg br_target mem_wen rf_wen wb_sel wb_addr jmp_flg
# kill expected(rf_wdata or redirect_pc), all columns hex
1 00000100 00a00093 00000000 0000000a 0 00000000 0 1 1 01 0 0 0000000a
1 00000104 00000117 00000000 00000000 0 00000000 0 1 3 02 0 0 00000108
1 00000108 12345013 00000000 12345678 0 00000000 0 1 1 00 0 0 00000000
1 0000010c 00112023 11223344 00000040 0 00000000 3 0 0 00 0 0 00000000
1 00000110 00111023 aaaa5566 00000040 0 00000000 2 0 0 00 0 0 00000000
1 00000114 00110023 ffffff77 00000040 0 00000000 1 0 0 00 0 0 00000000
1 00000118 04002183 00000000 00000040 0 00000000 8 1 2 03 0 0 11225577
1 0000011c 00112223 12348f80 00000044 0 00000000 3 0 0 00 0 0 00000000
1 00000120 04400203 00000000 00000044 0 00000000 4 1 2 04 0 0 ffffff80
1 00000124 04404283 00000000 00000044 0 00000000 5 1 2 05 0 0 00000080
1 00000128 04401303 00000000 00000044 0 00000000 6 1 2 06 0 0 ffff8f80
1 0000012c 04405383 00000000 00000044 0 00000000 7 1 2 07 0 0 00008f80
1 00000130 00112423 0badf00d 00000048 0 00000000 3 0 0 00 0 0 00000000
1 00000134 05500413 00000000 00000055 0 00000000 0 1 1 08 0 0 00000055
1 00000138 1c000463 00000000 00000000 1 00000300 0 0 0 00 0 0 00000300
1 0000013c 00112423 deadbeef 00000048 0 00000000 3 0 0 00 0 1 00000000
1 00000300 40000067 00000000 00000400 0 00000000 0 0 0 00 1 0 00000400
1 00000304 09900493 00000000 00000099 0 00000000 0 1 1 09 0 1 00000000
1 00000400 04802503 00000000 00000048 0 00000000 8 1 2 0a 0 0 0badf00d
1 00000404 00000013 00000000 fe000000 0 00000000 0 1 1 1f 0 0 fe000000

/* tb_mem_wb_top.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_mem_wb_top;
    import core_pkg::*;

    localparam int RAM_WORDS    = 64;
    localparam int READ_LATENCY = 3;
    localparam int WAIT_LIMIT   = 50;

    typedef struct packed {
        ex_mem_t     bundle;
        logic        kill;
        logic [31:0] exp_val;
    } stim_t;

    typedef struct packed {
        logic        is_redirect;
        logic [4:0]  addr;
        logic [31:0] value;
    } result_t;

    logic        clk;
    logic        rst;
    ex_mem_t     ex_in;
    logic        stall;
    logic        rf_we;
    logic [4:0]  rf_waddr;
    logic [31:0] rf_wdata;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic        took;        // bundle consumed at the last rising edge.
    int unsigned rng;
    stim_t       stim_q[$];
    result_t     exp_q[$];

    mem_wb_top #(
        .RAM_WORDS    (RAM_WORDS),
        .READ_LATENCY (READ_LATENCY)
    ) u_mem_wb_top (
        .clk         (clk),
        .rst         (rst),
        .ex_in       (ex_in),
        .stall       (stall),
        .rf_we       (rf_we),
        .rf_waddr    (rf_waddr),
        .rf_wdata    (rf_wdata),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        took <= !rst && !stall;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic value_error(input string msg);
        stop_on_error($sformatf("ERR %0t: %s", $time, msg));
    endtask

    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic ex_mem_t idle_bundle();
        ex_mem_t b;
        b         = '0;
        b.reg_pc  = REGPC_NOP;
        b.inst    = INST_NOP;
        b.mem_wen = MEN_X;
        b.wb_sel  = WB_X;
        return b;
    endfunction

    task automatic load_stimulus();
        int          fd;
        int          n;
        string       line;
        stim_t       s;
        logic [31:0] v_valid, v_pc, v_inst, v_rs2, v_alu, v_br, v_bt;
        logic [31:0] v_mw, v_rf, v_sel, v_wa, v_jmp, v_kill, v_exp;
        fd = $fopen("mem_stimulus.txt", "r");
        if (fd == 0) begin
            stop_on_error("cannot open mem_stimulus.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 2 || line.getc(0) == 8'h23) begin
                continue; // blank or comment.
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        v_valid, v_pc, v_inst, v_rs2, v_alu, v_br, v_bt,
                        v_mw, v_rf, v_sel, v_wa, v_jmp, v_kill, v_exp);
            if (n != 14) begin
                stop_on_error($sformatf("malformed stimulus line: %s", line));
            end
            s.bundle.valid     = v_valid[0];
            s.bundle.reg_pc    = v_pc;
            s.bundle.inst      = v_inst;
            s.bundle.rs2_data  = v_rs2;
            s.bundle.alu_out   = v_alu;
            s.bundle.br_flg    = v_br[0];
            s.bundle.br_target = v_bt;
            s.bundle.mem_wen   = mem_op_e'(v_mw[3:0]);
            s.bundle.rf_wen    = v_rf[0];
            s.bundle.wb_sel    = wb_sel_e'(v_sel[3:0]);
            s.bundle.wb_addr   = v_wa[4:0];
            s.bundle.jmp_flg   = v_jmp[0];
            s.kill             = v_kill[0];
            s.exp_val          = v_exp;
            stim_q.push_back(s);
        end
        $fclose(fd);
    endtask

    // waits until the bundle on ex_in is taken by the memory stage.
    task automatic wait_consumed(output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                stop_on_error("timeout: stall stayed high and the bundle was never taken");
            end
        end while (!took);
    endtask

    // writes need valid, rf_wen and a nonzero rd; redirects need br or jmp.
    task automatic queue_results(input stim_t s);
        result_t r;
        if (s.kill || !s.bundle.valid) begin
            return;
        end
        if (s.bundle.rf_wen && s.bundle.wb_addr != 5'd0) begin
            r.is_redirect = 1'b0;
            r.addr        = s.bundle.wb_addr;
            r.value       = s.exp_val;
            exp_q.push_back(r);
        end
        if (s.bundle.br_flg || s.bundle.jmp_flg) begin
            r.is_redirect = 1'b1;
            r.addr        = 5'd0;
            r.value       = s.exp_val;
            exp_q.push_back(r);
        end
    endtask

    always @(negedge clk) begin
        result_t r;
        if (!rst) begin
            assert (u_mem_wb_top.u_mem_stage.u_chk.fail_count == 0)
                else stop_on_error("a protocol assertion on the memory stage failed");
            if (rf_we) begin
                assert (exp_q.size() != 0)
                    else stop_on_error($sformatf("register write to x%0d that no bundle asked for",
                                                 rf_waddr));
                r = exp_q.pop_front();
                assert (!r.is_redirect)
                    else stop_on_error("register write came where a redirect was due");
                assert (rf_waddr == r.addr && rf_wdata == r.value)
                    else value_error($sformatf("write x%0d = %h, expected x%0d = %h",
                                               rf_waddr, rf_wdata, r.addr, r.value));
            end
            if (redirect) begin
                assert (exp_q.size() != 0)
                    else stop_on_error("redirect that no bundle asked for");
                r = exp_q.pop_front();
                assert (r.is_redirect)
                    else stop_on_error("redirect came where a register write was due");
                assert (redirect_pc == r.value)
                    else value_error($sformatf("redirect to %h, expected %h",
                                               redirect_pc, r.value));
            end
        end
    end

    initial begin
        stim_t s;
        int    cycles;
        int    gap;
        clk   = 1'b0;
        rst   = 1'b1;
        ex_in = idle_bundle();
        rng   = 32'd75806;
        load_stimulus();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        foreach (stim_q[i]) begin
            s     = stim_q[i];
            ex_in = s.bundle;
            wait_consumed(cycles);
            if (s.kill) begin
                assert (cycles == 1)
                    else stop_on_error("killed bundle was not taken in the hazard cycle");
            end
            queue_results(s);
            // the line after a branch must meet the hazard cycle.
            if (!(s.bundle.br_flg || s.bundle.jmp_flg)) begin
                rng = lcg_next(rng);
                gap = int'((rng >> 16) % 3);
                for (int b = 0; b < gap; b++) begin
                    ex_in = idle_bundle();
                    wait_consumed(cycles);
                end
            end
        end
        ex_in  = idle_bundle();
        cycles = 0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                stop_on_error("timeout: expected register writes or redirects never came");
            end
        end
        repeat (6) @(negedge clk); // catch stray writes.
        if (u_mem_wb_top.u_mem_stage.u_chk.fail_count == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            stop_on_error("a protocol assertion on the memory stage failed");
        end
    end

endmodule

`default_nettype wire

/* mem_stage_chk.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_stage_chk (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     stall,
    input  wire core_pkg::mem_cmd_t mem_cmd,
    input  wire                     cmd_ready,
    input  wire                     rdata_valid
);

    int   fail_count = 0;
    logic read_pending;

    always_ff @(posedge clk) begin
        if (rst) begin
            read_pending <= 1'b0;
        end else if (rdata_valid) begin
            read_pending <= 1'b0;
        end else if (mem_cmd.start && cmd_ready && !mem_cmd.write) begin
            read_pending <= 1'b1; // read accepted.
        end
    end

    a_no_start_in_read: assert property (@(posedge clk) disable iff (rst)
        read_pending |-> !mem_cmd.start)
        else begin
            fail_count = fail_count + 1;
            $error("memory command started while a read is outstanding");
        end

    a_valid_not_ready: assert property (@(posedge clk) disable iff (rst)
        rdata_valid |-> !cmd_ready)
        else begin
            fail_count = fail_count + 1;
            $error("rdata_valid high while cmd_ready is high");
        end

    a_stall_after_rst: assert property (@(posedge clk) rst |=> !stall)
        else begin
            fail_count = fail_count + 1;
            $error("stall high right after reset");
        end

endmodule

bind mem_stage mem_stage_chk u_chk (
    .clk         (clk),
    .rst         (rst),
    .stall       (stall),
    .mem_cmd     (mem_cmd),
    .cmd_ready   (cmd_ready),
    .rdata_valid (rdata_valid)
);

`default_nettype wire

/* mem_wb_top.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_wb_top #(
    parameter int RAM_WORDS    = 256,
    parameter int READ_LATENCY = 2
) (
    input  wire                    clk,
    input  wire                    rst,
    input  wire core_pkg::ex_mem_t ex_in,
    output logic                   stall,
    output logic                   rf_we,
    output logic [4:0]             rf_waddr,
    output logic [31:0]            rf_wdata,
    output logic                   redirect,
    output logic [31:0]            redirect_pc
);
    import core_pkg::*;

    mem_cmd_t    mem_cmd;
    mem_wb_t     mem_out;
    logic        cmd_ready;
    logic [31:0] rdata;
    logic        rdata_valid;
    logic        branch_hazard;

    mem_stage u_mem_stage (
        .clk           (clk),
        .rst           (rst),
        .ex_in         (ex_in),
        .branch_hazard (branch_hazard),
        .stall         (stall),
        .mem_cmd       (mem_cmd),
        .cmd_ready     (cmd_ready),
        .rdata         (rdata),
        .rdata_valid   (rdata_valid),
        .mem_out       (mem_out)
    );

    data_ram #(
        .RAM_WORDS    (RAM_WORDS),
        .READ_LATENCY (READ_LATENCY)
    ) u_data_ram (
        .clk         (clk),
        .rst         (rst),
        .mem_cmd     (mem_cmd),
        .cmd_ready   (cmd_ready),
        .rdata       (rdata),
        .rdata_valid (rdata_valid)
    );

    wb_stage u_wb_stage (
        .clk           (clk),
        .rst           (rst),
        .mem_out       (mem_out),
        .branch_hazard (branch_hazard),
        .rf_we         (rf_we),
        .rf_waddr      (rf_waddr),
        .rf_wdata      (rf_wdata),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc)
    );

endmodule

`default_nettype wire

/* wb_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module wb_stage (
    input  wire                    clk,
    input  wire                    rst,
    input  wire core_pkg::mem_wb_t mem_out,
    output logic                   branch_hazard,
    output logic                   rf_we,
    output logic [4:0]             rf_waddr,
    output logic [31:0]            rf_wdata,
    output logic                   redirect,
    output logic [31:0]            redirect_pc
);
    import core_pkg::*;

    logic [31:0] wb_value;
    logic [31:0] target;

    always_comb begin
        case (mem_out.wb_sel)
            WB_ALU:  wb_value = mem_out.alu_out;
            WB_MEM:  wb_value = mem_out.read_data;
            WB_PC:   wb_value = mem_out.reg_pc + 32'd4; // link address.
            default: wb_value = '0;
        endcase
    end

    assign branch_hazard = mem_out.valid && (mem_out.br_flg || mem_out.jmp_flg);
    assign target        = mem_out.br_flg ? mem_out.br_target : mem_out.alu_out;

    always_ff @(posedge clk) begin
        if (rst) begin
            rf_we    <= 1'b0;
            redirect <= 1'b0;
        end else begin
            rf_we    <= mem_out.valid && mem_out.rf_wen && mem_out.wb_addr != 5'd0;
            redirect <= branch_hazard;
        end
    end

    always_ff @(posedge clk) begin
        rf_waddr    <= mem_out.wb_addr;
        rf_wdata    <= wb_value;
        redirect_pc <= target;
    end

endmodule

`default_nettype wire

/* data_ram.sv */
`timescale 1ns/1ns
`default_nettype none

module data_ram #(
    parameter int RAM_WORDS    = 256,
    parameter int READ_LATENCY = 2
) (
    input  wire                     clk,
    input  wire                     rst,
    input  wire core_pkg::mem_cmd_t mem_cmd,
    output logic                    cmd_ready,
    output logic [31:0]             rdata,
    output logic                    rdata_valid
);

    localparam int AW = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;
    localparam int CW = (READ_LATENCY > 1) ? $clog2(READ_LATENCY) : 1;

    logic [31:0]   mem [RAM_WORDS];
    logic [AW-1:0] idx;
    logic          busy;
    logic [CW-1:0] count;
    logic          accept;

    initial begin
        for (int i = 0; i < RAM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    assign idx         = mem_cmd.addr[AW+1:2]; // low two bits ignored.
    assign accept      = mem_cmd.start && !busy;
    assign cmd_ready   = !busy;
    assign rdata_valid = busy && count == '0;

    // byte-mask merge, done in the accept cycle.
    always @(posedge clk) begin
        if (accept && mem_cmd.write) begin
            mem[idx] <= (mem[idx] & ~mem_cmd.wmask) | (mem_cmd.wdata & mem_cmd.wmask);
        end
    end

    // no write can land while busy, so the word is taken at accept.
    always_ff @(posedge clk) begin
        if (accept && !mem_cmd.write) begin
            rdata <= mem[idx];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (busy) begin
            if (count == '0) begin
                busy <= 1'b0;
            end else begin
                count <= count - 1'b1;
            end
        end else if (accept && !mem_cmd.write) begin
            busy  <= 1'b1;
            count <= CW'(READ_LATENCY - 1);
        end
    end

endmodule

`default_nettype wire

/* mem_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_stage (
    input  wire                     clk,
    input  wire                     rst,
    input  wire core_pkg::ex_mem_t  ex_in,
    input  wire                     branch_hazard,
    output logic                    stall,
    output core_pkg::mem_cmd_t      mem_cmd,
    input  wire                     cmd_ready,
    input  wire  [31:0]             rdata,
    input  wire                     rdata_valid,
    output core_pkg::mem_wb_t       mem_out
);
    import core_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT_READY,
        S_WAIT_READ
    } state_e;

    state_e  state;
    state_e  cur_state;    // hazard forces idle.
    ex_mem_t cur;
    ex_mem_t save;
    mem_wb_t out_next;
    logic    cur_store;
    logic    cur_load;
    logic    save_store;
    logic    done_cur;
    logic    done_save;

    function automatic logic is_store_op(input mem_op_e op);
        return op == MEN_SB || op == MEN_SH || op == MEN_SW;
    endfunction

    function automatic logic [31:0] wmask_of(input mem_op_e op);
        case (op)
            MEN_SB:  return 32'h0000_00ff;
            MEN_SH:  return 32'h0000_ffff;
            default: return 32'hffff_ffff;
        endcase
    endfunction

    function automatic logic [31:0] load_ext(input mem_op_e op, input logic [31:0] d);
        case (op)
            MEN_LB:  return {{24{d[7]}}, d[7:0]};
            MEN_LBU: return {24'h0, d[7:0]};
            MEN_LH:  return {{16{d[15]}}, d[15:0]};
            MEN_LHU: return {16'h0, d[15:0]};
            default: return d;
        endcase
    endfunction

    function automatic mem_wb_t to_wb(input ex_mem_t b, input logic [31:0] rd);
        mem_wb_t w;
        w.valid     = b.valid;
        w.reg_pc    = b.reg_pc;
        w.inst      = b.inst;
        w.read_data = rd;
        w.alu_out   = b.alu_out;
        w.br_flg    = b.br_flg;
        w.br_target = b.br_target;
        w.rf_wen    = b.rf_wen;
        w.wb_sel    = b.wb_sel;
        w.wb_addr   = b.wb_addr;
        w.jmp_flg   = b.jmp_flg;
        return w;
    endfunction

    // a branch in writeback turns the incoming bundle into a bubble.
    always_comb begin
        cur = ex_in;
        if (branch_hazard) begin
            cur         = '0;
            cur.reg_pc  = REGPC_NOP;
            cur.inst    = INST_NOP;
            cur.mem_wen = MEN_X;
            cur.wb_sel  = WB_X;
        end
    end

    assign cur_state  = branch_hazard ? S_IDLE : state;
    assign cur_store  = cur.valid && is_store_op(cur.mem_wen);
    assign cur_load   = cur.valid && !is_store_op(cur.mem_wen) && cur.mem_wen != MEN_X;
    assign save_store = is_store_op(save.mem_wen);

    assign done_cur  = cur_state == S_IDLE && !cur_load && !(cur_store && !cmd_ready);
    assign done_save = (cur_state == S_WAIT_READY && save_store && cmd_ready) ||
                       (cur_state == S_WAIT_READ && rdata_valid);
    assign stall     = !(done_cur || done_save);

    always_comb begin
        mem_cmd = '0;
        case (cur_state)
            S_IDLE: begin
                mem_cmd.start = cur_store || cur_load;
                mem_cmd.write = cur_store;
                mem_cmd.addr  = cur.alu_out;
                mem_cmd.wdata = cur.rs2_data;
                mem_cmd.wmask = wmask_of(cur.mem_wen);
            end
            S_WAIT_READY: begin // reissue from the saved bundle.
                mem_cmd.start = cmd_ready;
                mem_cmd.write = save_store;
                mem_cmd.addr  = save.alu_out;
                mem_cmd.wdata = save.rs2_data;
                mem_cmd.wmask = wmask_of(save.mem_wen);
            end
            default: ;
        endcase
    end

    always_comb begin
        if (done_cur) begin
            out_next = to_wb(cur, 32'hffff_ffff);
        end else if (done_save && cur_state == S_WAIT_READ) begin
            out_next = to_wb(save, load_ext(save.mem_wen, rdata));
        end else if (done_save) begin
            out_next = to_wb(save, 32'hffff_ffff);
        end else begin
            out_next        = '0;
            out_next.reg_pc = REGPC_NOP;
            out_next.inst   = INST_NOP;
            out_next.wb_sel = WB_X;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            case (cur_state)
                S_IDLE: begin
                    if (cur_load) begin
                        state <= cmd_ready ? S_WAIT_READ : S_WAIT_READY;
                    end else if (cur_store && !cmd_ready) begin
                        state <= S_WAIT_READY;
                    end else begin
                        state <= S_IDLE;
                    end
                end
                S_WAIT_READY: begin
                    if (cmd_ready) begin
                        state <= save_store ? S_IDLE : S_WAIT_READ;
                    end
                end
                S_WAIT_READ: begin
                    if (rdata_valid) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cur_state == S_IDLE) begin
            save <= cur;
        end
    end

    always_ff @(posedge clk) begin
        mem_out <= out_next;
        if (rst) begin
            mem_out.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* core_pkg.sv */
`default_nettype none

package core_pkg;

    typedef enum logic [3:0] {
        MEN_X   = 4'd0,
        MEN_SB  = 4'd1,
        MEN_SH  = 4'd2,
        MEN_SW  = 4'd3,
        MEN_LB  = 4'd4,
        MEN_LBU = 4'd5,
        MEN_LH  = 4'd6,
        MEN_LHU = 4'd7,
        MEN_LW  = 4'd8
    } mem_op_e;

    typedef enum logic [3:0] {
        WB_X   = 4'd0,
        WB_ALU = 4'd1,
        WB_MEM = 4'd2,
        WB_PC  = 4'd3
    } wb_sel_e;

    localparam logic [31:0] INST_NOP  = 32'h0000_0013; // addi x0, x0, 0.
    localparam logic [31:0] REGPC_NOP = 32'hffff_ffff;

    typedef struct packed {
        logic        valid;
        logic [31:0] reg_pc;
        logic [31:0] inst;
        logic [31:0] rs2_data;
        logic [31:0] alu_out;    // also the memory address.
        logic        br_flg;
        logic [31:0] br_target;
        mem_op_e     mem_wen;
        logic        rf_wen;
        wb_sel_e     wb_sel;
        logic [4:0]  wb_addr;
        logic        jmp_flg;
    } ex_mem_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] reg_pc;
        logic [31:0] inst;
        logic [31:0] read_data;  // already extended.
        logic [31:0] alu_out;
        logic        br_flg;
        logic [31:0] br_target;
        logic        rf_wen;
        wb_sel_e     wb_sel;
        logic [4:0]  wb_addr;
        logic        jmp_flg;
    } mem_wb_t;

    typedef struct packed {
        logic        start;
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] wmask;
    } mem_cmd_t;

endpackage

`default_nettype wire
